/* src.f */
+incdir+test
rtl/regbank_pkg.sv
rtl/sfr_decode.sv
rtl/sfr_command.sv
rtl/event_status.sv
rtl/reset_ctrl.sv
rtl/control_regs.sv
rtl/p0_watch.sv
rtl/regbank_top.sv
test/tb_regbank.sv

/* test/tb_regbank_model.svh */
`ifndef TB_REGBANK_MODEL_SVH
`define TB_REGBANK_MODEL_SVH

// ============================================================
// Reference model state
// ============================================================
sfr_byte_t m_txctl, m_msk0, m_msk1, m_rxctl, m_gpf, m_dec, m_p0msk;
sfr_byte_t m_sta0, m_sta1, m_p0sta;
sfr_byte_t m_p0_prev;                       // Port value seen last cycle

task automatic model_reset();
   m_txctl   = 8'h00;
   m_msk0    = 8'h00;
   m_msk1    = 8'h00;
   m_rxctl   = 8'h00;
   m_gpf     = 8'h00;
   m_dec     = 8'h00;
   m_p0msk   = 8'h00;
   m_sta0    = 8'h00;
   m_sta1    = 8'h00;
   m_p0sta   = 8'h00;
   m_p0_prev = 8'h00;
endtask

function automatic sfr_byte_t model_read(input sfr_byte_t addr);
   case (addr)
      TXCTL:   return m_txctl;
      FFIO:    return i_fifo_rdat;
      STA0:    return m_sta0;
      STA1:    return m_sta1;
      MSK0:    return m_msk0;
      MSK1:    return m_msk1;
      RXCTL:   return m_rxctl;
      GPF:     return m_gpf;
      DEC:     return m_dec;
      P0MSK:   return m_p0msk;
      P0STA:   return m_p0sta;
      default: return 8'hff;                // CMD is write-only too
   endcase
endfunction

// Next state from the inputs applied in this cycle
task automatic model_update();
   logic      wr_cmd;
   logic      key_ok;
   sfr_byte_t set0;
   sfr_byte_t set1;
   wr_cmd = i_sfr_w && (i_sfr_addr == CMD);
   key_ok = (m_dec == DEC_KEY);
   set0   = i_cany0 ? 8'h00 : i_rx_set;
   set1   = i_cany0 ? 8'h00 : i_tx_set;
   if (i_sfr_w && i_sfr_addr == STA0)  m_sta0  = m_sta0 & ~i_sfr_wdat;
   if (i_sfr_w && i_sfr_addr == STA1)  m_sta1  = m_sta1 & ~i_sfr_wdat;
   if (i_sfr_w && i_sfr_addr == P0STA) m_p0sta = m_p0sta & ~i_sfr_wdat;
   m_sta0    = m_sta0 | set0;               // Set beats clear
   m_sta1    = m_sta1 | set1;
   m_p0sta   = m_p0sta | (i_p0 ^ m_p0_prev);
   m_p0_prev = i_p0;
   if (wr_cmd && key_ok && i_sfr_wdat == CMD_PHYRST) begin
      m_sta0 = 8'h00;                       // PHY reset wipes event status
      m_sta1 = 8'h00;
   end
   if (i_sfr_w) begin
      case (i_sfr_addr)
         TXCTL:   m_txctl = i_sfr_wdat;
         MSK0:    m_msk0  = i_sfr_wdat;
         MSK1:    m_msk1  = i_sfr_wdat;
         RXCTL:   m_rxctl = i_sfr_wdat;
         GPF:     m_gpf   = i_sfr_wdat;
         DEC:     m_dec   = i_sfr_wdat;
         P0MSK:   m_p0msk = i_sfr_wdat;
         default: ;
      endcase
   end
   if (wr_cmd && key_ok && (i_sfr_wdat == CMD_PHYRST || i_sfr_wdat == CMD_SYSRST)) begin
      m_dec = 8'h00;                        // Key used up
   end
endtask

// ============================================================
// Compare tasks
// ============================================================
task automatic check_byte(input string what, input sfr_byte_t got, input sfr_byte_t exp);
   if (got !== exp) begin
      abort_run($sformatf("error %0t: %s is %h, expected %h", $time, what, got, exp));
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   if (got !== exp) begin
      abort_run($sformatf("error %0t: %s is %b, expected %b", $time, what, got, exp));
   end
endtask

task automatic check_intr(input logic [N_INTR-1:0] got, input logic [N_INTR-1:0] exp);
   if (got !== exp) begin
      abort_run($sformatf("error %0t: o_intr is %b, expected %b", $time, got, exp));
   end
endtask

task automatic check_field(input string what, input logic [6:0] got, input logic [6:0] exp);
   if (got !== exp) begin
      abort_run($sformatf("error %0t: %s is %h, expected %h", $time, what, got, exp));
   end
endtask

`endif

/* test/tb_regbank.sv */
`timescale 1ns/1ps

module tb_regbank import regbank_pkg::*; ();

   localparam int          CLK_PERIOD = 100;
   localparam logic [15:0] LFSR_SEED  = 16'd41611;
   localparam logic [15:0] LFSR_TAPS  = 16'hb400;  // x^16+x^14+x^13+x^11+1
   localparam int          N_RW       = 40;
   localparam int          N_STA      = 40;
   localparam int          N_P0       = 30;
   localparam int          N_ITEMS    = N_RW + N_STA + N_P0 + 6;
   localparam int          N_RSEQ     = 3;         // Power-on, PHY and system reset
   localparam int          WD_CYCLES  = N_ITEMS * 200 + N_RSEQ * 64;

   logic              clk;
   logic              rrstz;
   sfr_byte_t         i_sfr_addr, i_sfr_wdat, i_fifo_rdat;
   sfr_byte_t         i_rx_set, i_tx_set, i_p0;
   logic              i_sfr_w, i_sfr_r, i_bus_idle, i_cany0, i_goidle, i_c0set;
   sfr_byte_t         o_sfr_rdat;
   logic [N_INTR-1:0] o_intr;
   logic              o_srstz, o_prstz, o_fiforst, o_discard, o_fifopsh, o_fifopop;
   logic [6:0]        o_txauto, o_rxords_ena;
   logic              o_txendk;
   logic [15:0]       lfsr;

   regbank_top dut_i (
      .clk (clk), .rrstz (rrstz), .i_sfr_addr (i_sfr_addr), .i_sfr_wdat (i_sfr_wdat),
      .i_sfr_w (i_sfr_w), .i_sfr_r (i_sfr_r), .i_fifo_rdat (i_fifo_rdat),
      .i_rx_set (i_rx_set), .i_tx_set (i_tx_set), .i_p0 (i_p0),
      .i_bus_idle (i_bus_idle), .i_cany0 (i_cany0), .i_goidle (i_goidle),
      .i_c0set (i_c0set), .o_sfr_rdat (o_sfr_rdat), .o_intr (o_intr),
      .o_srstz (o_srstz), .o_prstz (o_prstz), .o_fiforst (o_fiforst),
      .o_discard (o_discard), .o_fifopsh (o_fifopsh), .o_fifopop (o_fifopop),
      .o_txauto (o_txauto), .o_txendk (o_txendk), .o_rxords_ena (o_rxords_ena)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   `include "tb_regbank_model.svh"

   // ============================================================
   // Clock, watchdog and random source
   // ============================================================
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      abort_run("Watchdog timeout, the test sequence did not finish in time");
   end

   // Galois LFSR, one step per bit taken
   function automatic sfr_byte_t rand_byte(input int n);
      sfr_byte_t v;
      int        k;
      v = 8'h00;
      for (k = 0; k < n; k++) begin
         v    = {v[6:0], lfsr[0]};
         lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);
      end
      return v;
   endfunction

   function automatic sfr_byte_t rw_addr(input int sel);
      case (sel)
         0:       return TXCTL;
         1:       return MSK0;
         2:       return MSK1;
         3:       return RXCTL;
         4:       return GPF;
         5:       return DEC;
         default: return P0MSK;
      endcase
   endfunction

   // ============================================================
   // Bus cycles, all starting on a falling edge
   // ============================================================
   task automatic check_state();
      logic [6:0] exp_ords;
      logic       exp_fr;
      logic       exp_dc;
      exp_ords = m_rxctl[6:0];
      if (exp_ords == 7'h00) exp_ords[4] = 1'b1;   // SOP debug forced on
      exp_fr = (i_sfr_w && i_sfr_addr == CMD && i_sfr_wdat == CMD_FIFORST) || i_c0set;
      exp_dc = i_sfr_w && i_sfr_addr == CMD && i_sfr_wdat == CMD_DISCARD;
      check_intr(o_intr, {|(m_p0sta & m_p0msk), |(m_sta1 & m_msk1), |(m_sta0 & m_msk0)});
      check_field("o_txauto", o_txauto, m_txctl[6:0]);
      check_bit("o_txendk", o_txendk, m_txctl[7]);
      check_field("o_rxords_ena", o_rxords_ena, exp_ords);
      check_bit("o_fiforst", o_fiforst, exp_fr);
      check_bit("o_discard", o_discard, exp_dc);
      check_bit("o_fifopsh", o_fifopsh, i_sfr_w && i_sfr_addr == FFIO);
      check_bit("o_fifopop", o_fifopop, i_sfr_r && i_sfr_addr == FFIO);
      check_bit("o_srstz", o_srstz, 1'b1);
      check_bit("o_prstz", o_prstz, 1'b1);
      if (i_sfr_r) check_byte("o_sfr_rdat", o_sfr_rdat, model_read(i_sfr_addr));
   endtask

   task automatic tick();
      #10;                                  // Let the comb outputs settle
      check_state();
      model_update();
      @(negedge clk);
   endtask

   task automatic bus_idle();
      i_sfr_w = 1'b0;
      i_sfr_r = 1'b0;
   endtask

   task automatic sfr_write(input sfr_byte_t addr, input sfr_byte_t data);
      i_sfr_addr = addr;
      i_sfr_wdat = data;
      i_sfr_w    = 1'b1;
      i_sfr_r    = 1'b0;
      tick();
      bus_idle();
   endtask

   task automatic sfr_read(input sfr_byte_t addr);
      i_sfr_addr = addr;
      i_sfr_w    = 1'b0;
      i_sfr_r    = 1'b1;
      tick();
      bus_idle();
   endtask

   task automatic idle_cycle();
      bus_idle();
      tick();
   endtask

   task automatic wait_srstz(input logic level, input int max_cyc);
      int n;
      n = 0;
      while (o_srstz !== level) begin
         if (n == max_cyc) begin
            abort_run($sformatf("o_srstz did not go to %b within %0d cycles", level, max_cyc));
         end else begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic wait_prstz(input logic level, input int max_cyc);
      int n;
      n = 0;
      while (o_prstz !== level) begin
         if (n == max_cyc) begin
            abort_run($sformatf("o_prstz did not go to %b within %0d cycles", level, max_cyc));
         end else begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   // ============================================================
   // Test sequence
   // ============================================================
   initial begin
      int        i;
      sfr_byte_t data;
      rrstz       = 1'b0;
      i_sfr_addr  = 8'h00;
      i_sfr_wdat  = 8'h00;
      i_sfr_w     = 1'b0;
      i_sfr_r     = 1'b0;
      i_fifo_rdat = 8'h00;
      i_rx_set    = 8'h00;
      i_tx_set    = 8'h00;
      i_p0        = 8'h00;
      i_bus_idle  = 1'b1;
      i_cany0     = 1'b0;
      i_goidle    = 1'b0;
      i_c0set     = 1'b0;
      lfsr        = LFSR_SEED;
      model_reset();

      repeat (4) @(negedge clk);
      rrstz = 1'b1;
      @(negedge clk);
      check_bit("o_srstz after reset", o_srstz, 1'b0);  // Still in the synchronizer
      check_bit("o_prstz after reset", o_prstz, 1'b0);
      wait_srstz(1'b1, 4);

      // Plain registers and unmapped reads
      for (i = 0; i < N_RW; i++) begin
         data = rw_addr(rand_byte(3) % 7);
         sfr_write(data, rand_byte(8));
         sfr_read(data);
         i_fifo_rdat = rand_byte(8);
         sfr_read(rand_byte(8));
      end

      // Event status with W1C and interrupt masks
      for (i = 0; i < N_STA; i++) begin
         i_rx_set = rand_byte(8) & rand_byte(8);
         i_tx_set = rand_byte(8) & rand_byte(8);
         i_cany0  = (rand_byte(2) == 8'd0);
         data     = rand_byte(8);
         case (rand_byte(3))
            0:       sfr_write(STA0, data);
            1:       sfr_write(STA1, data);
            2:       sfr_read(STA0);
            3:       sfr_read(STA1);
            4:       sfr_write(MSK0, data);
            5:       sfr_write(MSK1, data);
            default: idle_cycle();
         endcase
      end
      i_cany0  = 1'b0;
      i_tx_set = 8'h00;
      i_rx_set = 8'h81;                      // Collides with the clear below
      sfr_write(STA0, 8'hff);
      i_rx_set = 8'h00;
      sfr_read(STA0);

      // Command strobes and FIFO port
      sfr_write(CMD, CMD_FIFORST);
      idle_cycle();
      sfr_write(CMD, CMD_DISCARD);
      idle_cycle();
      i_c0set = 1'b1;
      idle_cycle();
      i_c0set = 1'b0;
      idle_cycle();
      sfr_write(FFIO, rand_byte(8));
      i_fifo_rdat = rand_byte(8);
      sfr_read(FFIO);

      // PHY reset, first without the key
      i_rx_set = 8'h5a;
      i_tx_set = 8'ha5;
      idle_cycle();
      i_rx_set = 8'h00;
      i_tx_set = 8'h00;
      sfr_write(DEC, DEC_KEY ^ 8'h80);
      sfr_write(CMD, CMD_PHYRST);
      repeat (3) idle_cycle();
      sfr_read(STA0);
      sfr_write(DEC, DEC_KEY);
      i_cany0 = 1'b1;                       // Protocol layer still busy
      sfr_write(CMD, CMD_PHYRST);
      sfr_read(STA0);                       // Wiped in the command cycle
      sfr_read(STA1);
      idle_cycle();
      i_cany0  = 1'b0;
      i_rx_set = 8'h5a;                     // Events land while PHY reset runs
      i_tx_set = 8'ha5;
      wait_prstz(1'b0, 4);
      wait_prstz(1'b1, 4);
      i_rx_set = 8'h00;
      i_tx_set = 8'h00;
      sfr_read(STA0);
      sfr_read(STA1);
      sfr_read(DEC);

      // Port-0 change detect
      for (i = 0; i < N_P0; i++) begin
         i_p0 = i_p0 ^ (rand_byte(8) & rand_byte(8));
         data = rand_byte(8);
         case (rand_byte(2))
            0:       sfr_write(P0STA, data);
            1:       sfr_read(P0STA);
            2:       sfr_write(P0MSK, data);
            default: idle_cycle();
         endcase
      end
      i_p0 = 8'h00;
      idle_cycle();

      // System reset, stalled for a while by a busy bus
      sfr_write(GPF, 8'h3c);
      sfr_write(DEC, DEC_KEY);
      sfr_write(CMD, CMD_SYSRST);
      i_bus_idle = 1'b0;
      sfr_write(DEC, 8'h5a);                // Must be wiped by the reset
      repeat (20) idle_cycle();             // Longer than the run up to the window
      i_bus_idle = 1'b1;
      wait_srstz(1'b0, 24);
      wait_srstz(1'b1, 12);
      model_reset();
      sfr_read(TXCTL);
      sfr_read(STA0);
      sfr_read(STA1);
      sfr_read(MSK0);
      sfr_read(MSK1);
      sfr_read(RXCTL);
      sfr_read(GPF);
      sfr_read(DEC);
      sfr_read(P0MSK);
      sfr_read(P0STA);

      $display("All tests passed");
      $finish;
   end

endmodule

/* rtl/regbank_top.sv */
`timescale 1ns/1ps

module regbank_top import regbank_pkg::*; (
   input  logic              clk,
   input  logic              rrstz,
   input  sfr_byte_t         i_sfr_addr,
   input  sfr_byte_t         i_sfr_wdat,
   input  logic              i_sfr_w,
   input  logic              i_sfr_r,
   input  sfr_byte_t         i_fifo_rdat,
   input  sfr_byte_t         i_rx_set,
   input  sfr_byte_t         i_tx_set,
   input  sfr_byte_t         i_p0,
   input  logic              i_bus_idle,
   input  logic              i_cany0,
   input  logic              i_goidle,
   input  logic              i_c0set,
   output sfr_byte_t         o_sfr_rdat,
   output logic [N_INTR-1:0] o_intr,
   output logic              o_srstz,
   output logic              o_prstz,
   output logic              o_fiforst,
   output logic              o_discard,
   output logic              o_fifopsh,
   output logic              o_fifopop,
   output logic [6:0]        o_txauto,
   output logic              o_txendk,
   output logic [6:0]        o_rxords_ena
);

   sfr_byte_t txctl, sta0, sta1, msk0, msk1, rxctl, gpf, dec, p0msk, p0sta;
   logic we_txctl, we_sta0, we_sta1, we_msk0, we_msk1, we_cmd;
   logic we_rxctl, we_gpf, we_dec, we_p0msk, we_p0sta;
   logic reg_rstz, phy_busy, set_en, phyrst_cmd, sysrst_cmd;

   // ==========================================================
   // Bus decode and command port
   // ==========================================================
   sfr_decode u_decode (
      .i_sfr_addr (i_sfr_addr), .i_sfr_w (i_sfr_w), .i_sfr_r (i_sfr_r),
      .i_txctl (txctl), .i_sta0 (sta0), .i_sta1 (sta1), .i_msk0 (msk0),
      .i_msk1 (msk1), .i_rxctl (rxctl), .i_gpf (gpf), .i_dec (dec),
      .i_p0msk (p0msk), .i_p0sta (p0sta), .i_fifo_rdat (i_fifo_rdat),
      .o_we_txctl (we_txctl), .o_we_sta0 (we_sta0), .o_we_sta1 (we_sta1),
      .o_we_msk0 (we_msk0), .o_we_msk1 (we_msk1), .o_we_cmd (we_cmd),
      .o_we_rxctl (we_rxctl), .o_we_gpf (we_gpf), .o_we_dec (we_dec),
      .o_we_p0msk (we_p0msk), .o_we_p0sta (we_p0sta),
      .o_fifopsh (o_fifopsh), .o_fifopop (o_fifopop), .o_sfr_rdat (o_sfr_rdat)
   );

   sfr_command u_command (
      .clk (clk), .i_reg_rstz (reg_rstz), .i_we_dec (we_dec), .i_we_cmd (we_cmd),
      .i_wdat (i_sfr_wdat), .i_c0set (i_c0set), .o_dec (dec),
      .o_phyrst_cmd (phyrst_cmd), .o_sysrst_cmd (sysrst_cmd),
      .o_fiforst (o_fiforst), .o_discard (o_discard)
   );

   reset_ctrl u_reset (
      .clk (clk), .rrstz (rrstz), .i_bus_idle (i_bus_idle),
      .i_sysrst_cmd (sysrst_cmd), .i_phyrst_cmd (phyrst_cmd),
      .i_cany0 (i_cany0), .i_goidle (i_goidle), .o_srstz (o_srstz),
      .o_prstz (o_prstz), .o_reg_rstz (reg_rstz), .o_phy_busy (phy_busy),
      .o_set_en (set_en)
   );

   // ==========================================================
   // Registers
   // ==========================================================
   control_regs u_ctrl (
      .clk (clk), .i_reg_rstz (reg_rstz), .i_wdat (i_sfr_wdat),
      .i_we_txctl (we_txctl), .i_we_msk0 (we_msk0), .i_we_msk1 (we_msk1),
      .i_we_rxctl (we_rxctl), .i_we_gpf (we_gpf), .o_txctl (txctl),
      .o_msk0 (msk0), .o_msk1 (msk1), .o_rxctl (rxctl), .o_gpf (gpf),
      .o_txauto (o_txauto), .o_txendk (o_txendk), .o_rxords_ena (o_rxords_ena)
   );

   event_status u_sta0 (                    // RX events
      .clk (clk), .i_reg_rstz (reg_rstz), .i_clr_all (phy_busy),
      .i_set (i_rx_set), .i_set_en (set_en), .i_we (we_sta0),
      .i_wdat (i_sfr_wdat), .i_mask (msk0), .o_sta (sta0), .o_irq (o_intr[0])
   );

   event_status u_sta1 (                    // TX and FIFO events
      .clk (clk), .i_reg_rstz (reg_rstz), .i_clr_all (phy_busy),
      .i_set (i_tx_set), .i_set_en (set_en), .i_we (we_sta1),
      .i_wdat (i_sfr_wdat), .i_mask (msk1), .o_sta (sta1), .o_irq (o_intr[1])
   );

   p0_watch u_p0 (
      .clk (clk), .i_reg_rstz (reg_rstz), .i_p0 (i_p0), .i_we_p0msk (we_p0msk),
      .i_we_p0sta (we_p0sta), .i_wdat (i_sfr_wdat), .o_p0msk (p0msk),
      .o_p0sta (p0sta), .o_irq (o_intr[2])
   );

endmodule

/* rtl/p0_watch.sv */
`timescale 1ns/1ps

module p0_watch import regbank_pkg::*; (
   input  logic      clk,
   input  logic      i_reg_rstz,
   input  sfr_byte_t i_p0,
   input  logic      i_we_p0msk,
   input  logic      i_we_p0sta,
   input  sfr_byte_t i_wdat,
   output sfr_byte_t o_p0msk,
   output sfr_byte_t o_p0sta,
   output logic      o_irq
);

   sfr_byte_t d_p0;
   sfr_byte_t p0_chg;

   always_ff @(posedge clk or negedge i_reg_rstz) begin
      if (!i_reg_rstz) begin
         o_p0msk <= P0MSK_RST;
         d_p0    <= '0;
      end else begin
         if (i_we_p0msk) o_p0msk <= i_wdat;
         d_p0 <= i_p0;                      // Last cycle's port
      end
   end

   assign p0_chg = d_p0 ^ i_p0;             // Any edge

   event_status u_p0sta (
      .clk        (clk),
      .i_reg_rstz (i_reg_rstz),
      .i_clr_all  (1'b0),
      .i_set      (p0_chg),
      .i_set_en   (1'b1),
      .i_we       (i_we_p0sta),
      .i_wdat     (i_wdat),
      .i_mask     (o_p0msk),
      .o_sta      (o_p0sta),
      .o_irq      (o_irq)
   );

endmodule

/* rtl/control_regs.sv */
`timescale 1ns/1ps

module control_regs import regbank_pkg::*; (
   input  logic      clk,
   input  logic      i_reg_rstz,
   input  sfr_byte_t i_wdat,
   input  logic      i_we_txctl,
   input  logic      i_we_msk0,
   input  logic      i_we_msk1,
   input  logic      i_we_rxctl,
   input  logic      i_we_gpf,
   output sfr_byte_t o_txctl,
   output sfr_byte_t o_msk0,
   output sfr_byte_t o_msk1,
   output sfr_byte_t o_rxctl,
   output sfr_byte_t o_gpf,
   output logic [6:0] o_txauto,
   output logic      o_txendk,
   output logic [6:0] o_rxords_ena
);

   always_ff @(posedge clk or negedge i_reg_rstz) begin
      if (!i_reg_rstz) begin
         o_txctl <= TXCTL_RST;
         o_msk0  <= MSK0_RST;
         o_msk1  <= MSK1_RST;
         o_rxctl <= RXCTL_RST;
         o_gpf   <= GPF_RST;
      end else begin
         if (i_we_txctl) o_txctl <= i_wdat;
         if (i_we_msk0)  o_msk0  <= i_wdat;
         if (i_we_msk1)  o_msk1  <= i_wdat;
         if (i_we_rxctl) o_rxctl <= i_wdat;
         if (i_we_gpf)   o_gpf   <= i_wdat;
      end
   end

   // TXCTL fields
   assign o_txauto = o_txctl[6:0];          // Auto preamble/SOP/CRC/EOP
   assign o_txendk = o_txctl[7];            // Last byte sent as K-codes

   // With no ordered set enabled, SOP debug is forced on
   assign o_rxords_ena = o_rxctl[6:0] | {2'b00, ~|o_rxctl[6:0], 4'h0};

endmodule

/* rtl/reset_ctrl.sv */
`timescale 1ns/1ps

module reset_ctrl import regbank_pkg::*; (
   input  logic clk,
   input  logic rrstz,
   input  logic i_bus_idle,
   input  logic i_sysrst_cmd,
   input  logic i_phyrst_cmd,
   input  logic i_cany0,
   input  logic i_goidle,
   output logic o_srstz,
   output logic o_prstz,
   output logic o_reg_rstz,
   output logic o_phy_busy,
   output logic o_set_en
);

   logic [1:0]        sync_rstz;
   logic [GCNT_W-1:0] gcnt;        // Gray coded
   logic [GCNT_W-1:0] gcnt_bin;
   logic [GCNT_W-1:0] gcnt_inc;
   logic [GCNT_W-1:0] gcnt_nxt;
   logic              gcnt_run;
   logic              sys_win;
   logic [1:0]        phy_step;

   // ==========================================================
   // Reset synchronizer
   // ==========================================================
   always_ff @(posedge clk or negedge rrstz) begin
      if (!rrstz) begin
         sync_rstz <= 2'b00;
      end else begin
         sync_rstz <= {sync_rstz[0], 1'b1};
      end
   end

   // ==========================================================
   // System reset sequence
   // ==========================================================
   always_comb begin
      gcnt_bin[GCNT_W-1] = gcnt[GCNT_W-1];
      for (int i = GCNT_W-2; i >= 0; i--) begin
         gcnt_bin[i] = gcnt_bin[i+1] ^ gcnt[i];
      end
   end

   assign gcnt_inc = gcnt_bin + 1'b1;
   assign gcnt_nxt = gcnt_inc ^ (gcnt_inc >> 1);
   assign gcnt_run = i_sysrst_cmd | ((|gcnt) & i_bus_idle); // Stalls on busy bus

   always_ff @(posedge clk or negedge rrstz) begin
      if (!rrstz) begin
         gcnt <= '0;
      end else if (gcnt_run) begin
         gcnt <= gcnt_nxt;
      end
   end

   // Binary 17..23, decoded from Gray bits so it is glitch free
   assign sys_win = (gcnt[GCNT_W-1 -: 2] == 2'b11) && (gcnt[GCNT_W-3:0] != '0);

   // ==========================================================
   // PHY reset steps 0 -> 1 -> 2 -> 3 -> 0
   // ==========================================================
   always_ff @(posedge clk or negedge rrstz) begin
      if (!rrstz) begin
         phy_step <= 2'd0;
      end else if (phy_step == 2'd1) begin
         if (!i_cany0 || i_goidle) begin   // Wait for protocol layer
            phy_step <= 2'd2;
         end
      end else if (i_phyrst_cmd || (phy_step != 2'd0)) begin
         phy_step <= phy_step + 2'd1;
      end
   end

   assign o_srstz    = sync_rstz[1] & ~sys_win;
   assign o_prstz    = o_srstz & ~phy_step[1];   // Low in steps 2 and 3
   assign o_reg_rstz = rrstz & o_srstz;
   assign o_phy_busy = i_phyrst_cmd | phy_step[1];
   assign o_set_en   = ~i_cany0;

endmodule

/* rtl/event_status.sv */
`timescale 1ns/1ps

module event_status import regbank_pkg::*; (
   input  logic      clk,
   input  logic      i_reg_rstz,
   input  logic      i_clr_all,
   input  sfr_byte_t i_set,
   input  logic      i_set_en,
   input  logic      i_we,
   input  sfr_byte_t i_wdat,
   input  sfr_byte_t i_mask,
   output sfr_byte_t o_sta,
   output logic      o_irq
);

   sfr_byte_t set_q;
   sfr_byte_t clr_q;

   assign set_q = i_set & {SFR_W{i_set_en}};
   assign clr_q = i_wdat & {SFR_W{i_we}};      // Write one to clear

   // Set wins over a same-cycle clear
   always_ff @(posedge clk or negedge i_reg_rstz) begin
      if (!i_reg_rstz) begin
         o_sta <= '0;
      end else if (i_clr_all) begin
         o_sta <= '0;
      end else begin
         o_sta <= (o_sta & ~clr_q) | set_q;
      end
   end

   assign o_irq = |(o_sta & i_mask);

endmodule

/* rtl/sfr_command.sv */
`timescale 1ns/1ps

module sfr_command import regbank_pkg::*; (
   input  logic      clk,
   input  logic      i_reg_rstz,
   input  logic      i_we_dec,
   input  logic      i_we_cmd,
   input  sfr_byte_t i_wdat,
   input  logic      i_c0set,
   output sfr_byte_t o_dec,
   output logic      o_phyrst_cmd,
   output logic      o_sysrst_cmd,
   output logic      o_fiforst,
   output logic      o_discard
);

   cmd_e cmd;
   logic key_ok;
   logic clr_key;

   assign cmd    = cmd_e'(i_wdat);
   assign key_ok = (o_dec == DEC_KEY);

   // ==========================================================
   // Command decode
   // ==========================================================
   assign o_phyrst_cmd = i_we_cmd & (cmd == CMD_PHYRST) & key_ok;
   assign o_sysrst_cmd = i_we_cmd & (cmd == CMD_SYSRST) & key_ok;
   assign o_discard    = i_we_cmd & (cmd == CMD_DISCARD); // No key needed
   assign o_fiforst    = (i_we_cmd & (cmd == CMD_FIFORST)) | i_c0set;

   // Key is single use
   assign clr_key = o_phyrst_cmd | o_sysrst_cmd;

   always_ff @(posedge clk or negedge i_reg_rstz) begin
      if (!i_reg_rstz) begin
         o_dec <= DEC_RST;
      end else if (i_we_dec) begin
         o_dec <= i_wdat;
      end else if (clr_key) begin
         o_dec <= DEC_RST;
      end
   end

endmodule

/* rtl/sfr_decode.sv */
`timescale 1ns/1ps

module sfr_decode import regbank_pkg::*; (
   input  sfr_byte_t i_sfr_addr,
   input  logic      i_sfr_w,
   input  logic      i_sfr_r,
   input  sfr_byte_t i_txctl,
   input  sfr_byte_t i_sta0,
   input  sfr_byte_t i_sta1,
   input  sfr_byte_t i_msk0,
   input  sfr_byte_t i_msk1,
   input  sfr_byte_t i_rxctl,
   input  sfr_byte_t i_gpf,
   input  sfr_byte_t i_dec,
   input  sfr_byte_t i_p0msk,
   input  sfr_byte_t i_p0sta,
   input  sfr_byte_t i_fifo_rdat,
   output logic      o_we_txctl,
   output logic      o_we_sta0,
   output logic      o_we_sta1,
   output logic      o_we_msk0,
   output logic      o_we_msk1,
   output logic      o_we_cmd,
   output logic      o_we_rxctl,
   output logic      o_we_gpf,
   output logic      o_we_dec,
   output logic      o_we_p0msk,
   output logic      o_we_p0sta,
   output logic      o_fifopsh,
   output logic      o_fifopop,
   output sfr_byte_t o_sfr_rdat
);

   // Write strobes, valid in the bus cycle
   assign o_we_txctl = i_sfr_w & (i_sfr_addr == TXCTL);
   assign o_we_sta0  = i_sfr_w & (i_sfr_addr == STA0);
   assign o_we_sta1  = i_sfr_w & (i_sfr_addr == STA1);
   assign o_we_msk0  = i_sfr_w & (i_sfr_addr == MSK0);
   assign o_we_msk1  = i_sfr_w & (i_sfr_addr == MSK1);
   assign o_we_cmd   = i_sfr_w & (i_sfr_addr == CMD);
   assign o_we_rxctl = i_sfr_w & (i_sfr_addr == RXCTL);
   assign o_we_gpf   = i_sfr_w & (i_sfr_addr == GPF);
   assign o_we_dec   = i_sfr_w & (i_sfr_addr == DEC);
   assign o_we_p0msk = i_sfr_w & (i_sfr_addr == P0MSK);
   assign o_we_p0sta = i_sfr_w & (i_sfr_addr == P0STA);

   assign o_fifopsh = i_sfr_w & (i_sfr_addr == FFIO); // 1T push
   assign o_fifopop = i_sfr_r & (i_sfr_addr == FFIO); // 1T pop

   // Read-back mux, CMD is write-only
   always_comb begin
      case (i_sfr_addr)
         TXCTL:   o_sfr_rdat = i_txctl;
         FFIO:    o_sfr_rdat = i_fifo_rdat;
         STA0:    o_sfr_rdat = i_sta0;
         STA1:    o_sfr_rdat = i_sta1;
         MSK0:    o_sfr_rdat = i_msk0;
         MSK1:    o_sfr_rdat = i_msk1;
         RXCTL:   o_sfr_rdat = i_rxctl;
         GPF:     o_sfr_rdat = i_gpf;
         DEC:     o_sfr_rdat = i_dec;
         P0MSK:   o_sfr_rdat = i_p0msk;
         P0STA:   o_sfr_rdat = i_p0sta;
         default: o_sfr_rdat = UNUSED_RD;
      endcase
   end

endmodule

/* rtl/regbank_pkg.sv */
package regbank_pkg;

   // ==========================================================
   // Widths and byte type
   // ==========================================================
   localparam int SFR_W  = 8;
   localparam int N_INTR = 3;               // {P0, STA1, STA0}
   localparam int GCNT_W = 5;               // System reset Gray counter

   typedef logic [SFR_W-1:0] sfr_byte_t;

   localparam sfr_byte_t UNUSED_RD = 8'hff; // Unmapped address readback
   localparam sfr_byte_t DEC_KEY   = 8'h7c; // Unlocks privileged commands

   // Control register reset values
   localparam sfr_byte_t TXCTL_RST = 8'h00;
   localparam sfr_byte_t MSK0_RST  = 8'h00;
   localparam sfr_byte_t MSK1_RST  = 8'h00;
   localparam sfr_byte_t RXCTL_RST = 8'h00;
   localparam sfr_byte_t GPF_RST   = 8'h00;
   localparam sfr_byte_t DEC_RST   = 8'h00;
   localparam sfr_byte_t P0MSK_RST = 8'h00;

   // ==========================================================
   // SFR address map and command codes
   // ==========================================================
   typedef enum logic [SFR_W-1:0] {
      TXCTL = 8'hb0,
      FFIO  = 8'hb2,
      STA0  = 8'hb3,
      STA1  = 8'hb4,
      MSK0  = 8'hb5,
      MSK1  = 8'hb6,
      CMD   = 8'hb7,
      RXCTL = 8'hbb,
      GPF   = 8'hbf,
      DEC   = 8'hc3,
      P0MSK = 8'hde,
      P0STA = 8'hdf
   } sfr_addr_e;

   typedef enum logic [SFR_W-1:0] {
      CMD_FIFORST = 8'h00,
      CMD_SYSRST  = 8'h55,                  // Needs key
      CMD_PHYRST  = 8'hc8,                  // Needs key
      CMD_DISCARD = 8'hdc
   } cmd_e;

endpackage
